// File: bench/unified_mem_stim.txt
1 S 2 00000040 deadbeef -
1 F 0 00000040 00000000 deadbeef
1 L 2 00000040 00000000 deadbeef
1 L 2 00000042 00000000 deadbeef
2 S 0 00000080 00000011 -
2 S 0 00000081 000000a2 -
2 S 0 00000082 00000033 -
2 S 0 00000083 555555c4 -
2 L 0 00000080 00000000 00000011
2 L 4 00000080 00000000 00000011
2 L 0 00000081 00000000 ffffffa2
2 L 4 00000081 00000000 000000a2
2 L 0 00000082 00000000 00000033
2 L 4 00000082 00000000 00000033
2 L 0 00000083 00000000 ffffffc4
2 L 4 00000083 00000000 000000c4
2 F 0 00000080 00000000 c433a211
3 S 2 00000100 11111111 -
3 S 1 00000100 00008a5b -
3 L 2 00000100 00000000 11118a5b
3 S 1 00000102 abcdf00d -
3 L 1 00000100 00000000 ffff8a5b
3 L 5 00000100 00000000 00008a5b
3 L 1 00000101 00000000 ffff8a5b
3 L 1 00000102 00000000 fffff00d
3 L 5 00000103 00000000 0000f00d
3 L 2 00000100 00000000 f00d8a5b
4 S 2 00000200 01020304 -
4 L 2 00000200 00000000 01020304
4 S 0 00000201 000000ff -
4 L 2 00000200 00000000 0102ff04
4 F 0 00000200 00000000 0102ff04
4 L 0 00000201 00000000 ffffffff
4 L 4 00000201 00000000 000000ff
4 L 5 00000202 00000000 00000102
5 L 3 00000200 00000000 00000000
5 S 2 00000300 a5a5a5a5 -
5 S 3 00000302 12345678 -
5 L 2 00000300 00000000 a578a5a5
5 L 6 00000300 00000000 00000000
5 L 7 00000300 00000000 00000000
5 S 2 fffffc10 600dcafe -
5 L 2 00000010 00000000 600dcafe
5 F 7 00000410 00000000 600dcafe
5 L 4 80000013 00000000 00000060
6 S 2 00000020 0badf00d -
6 S 0 00000021 00000077 -
7 F 0 00000020 00000000 0bad770d

// File: bench/unified_mem_tb.sv
`include "unified_mem_consts.svh"

module unified_mem_tb;

        localparam int DRIVE_DLY     = 2;               // input skew after the rising edge
        localparam int RESET_CYCLES  = 8;
        localparam int DRAIN_TIMEOUT = 16;              // cycles allowed for outstanding reads

        // one line of the stim file
        typedef struct packed {
                logic [15:0]                    test;           // test number, groups a burst
                unified_mem_pkg::mem_req_t      req;
                logic                           has_exp;        // low for stores
                logic [`UMEM_XLEN-1:0]          exp;            // expected resp_data
        } vec_t;

        logic                           clk;
        logic                           rst_n;
        logic                           req_valid;
        unified_mem_pkg::mem_req_t      req;
        logic                           resp_valid;
        logic [`UMEM_XLEN-1:0]          resp_data;

        vec_t                           vecs[$];        // whole stim file
        logic [`UMEM_XLEN-1:0]          exp_q[$];       // expected data, request order
        int                             issue_q[$];     // cycle of each read request
        logic [`UMEM_XLEN-1:0]          exp_data;
        int                             issue_cyc;
        logic [15:0]                    cur_test;       // 0 while in reset
        int                             cycle = 0;      // rising edges so far
        int                             errors = 0;
        int                             checks = 0;
        int                             tests_run = 0;
        int                             tests_failed = 0;

        unified_mem DUT (
                .clk            (clk),
                .rst_n          (rst_n),
                .req_valid      (req_valid),
                .req            (req),
                .resp_valid     (resp_valid),
                .resp_data      (resp_data)
        );

        //////////////////////////////////////////////////
        // clock and cycle count
        //////////////////////////////////////////////////
        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;                         // period 40
        end

        always @(posedge clk) cycle <= cycle + 1;

        //////////////////////////////////////////////////
        // helpers
        //////////////////////////////////////////////////
        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                checks++;
                if (got !== exp) begin
                        $display("FAILED %s: got 0x%08h expected 0x%08h (test %0d)",
                                 name, got, exp, cur_test);
                        errors++;
                end
        endtask

        task automatic load_stimulus();
                int             fd;
                int             n;
                int             line_no;
                int             tnum;
                logic [7:0]     op_c;                           // F, L or S
                logic [2:0]     f3;
                logic [31:0]    addr;
                logic [31:0]    wdata;
                logic [63:0]    exp_tok;                        // hex word or a dash
                logic [31:0]    exp_val;
                vec_t           v;

                line_no = 0;
                fd = $fopen("bench/unified_mem_stim.txt", "r");
                if (fd == 0) begin
                        $display("cannot open the stimulus file");
                        errors++;
                        return;
                end
                while (!$feof(fd)) begin
                        op_c    = '0;
                        exp_tok = '0;
                        n = $fscanf(fd, "%d %s %d %h %h %s", tnum, op_c, f3, addr, wdata,
                                    exp_tok);
                        if (n <= 0) begin
                                break;                          // end of file
                        end
                        line_no++;
                        if (n != 6) begin
                                $display("stimulus line %0d is incomplete", line_no);
                                errors++;
                                break;
                        end
                        v           = '0;
                        v.test      = tnum[15:0];
                        v.req.func3 = f3;
                        v.req.addr  = addr;
                        v.req.wdata = wdata;
                        v.has_exp   = (exp_tok != 64'("-"));
                        if (v.has_exp) begin
                                exp_val = '0;
                                n       = $sscanf(exp_tok, "%h", exp_val);
                                v.exp   = exp_val;
                        end
                        case (op_c)
                                "F": v.req.op = unified_mem_pkg::OP_FETCH;
                                "L": v.req.op = unified_mem_pkg::OP_LOAD;
                                "S": v.req.op = unified_mem_pkg::OP_STORE;
                                default: begin
                                        $display("stimulus line %0d has an unknown operation",
                                                 line_no);
                                        errors++;
                                end
                        endcase
                        // stores carry a dash, reads carry a value
                        if (v.has_exp == (v.req.op == unified_mem_pkg::OP_STORE)) begin
                                $display("stimulus line %0d has a misplaced expected value",
                                         line_no);
                                errors++;
                        end
                        vecs.push_back(v);
                end
                $fclose(fd);
                if (vecs.size() == 0) begin
                        $display("the stimulus file holds no vectors");
                        errors++;
                end
        endtask

        // one cycle strobe, back to back when called every cycle
        task automatic issue_request(input vec_t v);
                @(posedge clk);
                #DRIVE_DLY;
                req_valid = 1'b1;
                req       = v.req;
                if (v.has_exp) begin
                        exp_q.push_back(v.exp);
                        issue_q.push_back(cycle);               // sampled at the next edge
                end
        endtask

        task automatic wait_drain();
                int waited;

                waited = 0;
                while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
                        @(posedge clk);
                        waited++;
                end
                if (exp_q.size() != 0) begin
                        $display("test %0d: %0d response(s) never arrived within %0d cycles",
                                 cur_test, exp_q.size(), DRAIN_TIMEOUT);
                        errors++;
                        exp_q.delete();                         // resync for the next test
                        issue_q.delete();
                end
        endtask

        task automatic report_result(input int errs_before);
                tests_run++;
                if (errors == errs_before) begin
                        $display("test %0d: pass", cur_test);
                end else begin
                        tests_failed++;
                        $display("test %0d: fail, %0d error(s)", cur_test, errors - errs_before);
                end
        endtask

        //////////////////////////////////////////////////
        // response monitor
        //////////////////////////////////////////////////
        always @(negedge clk) begin
                if (exp_q.size() == 0) begin
                        check_value("resp_valid", 32'(resp_valid), 32'd0);     // idle or store
                end else if (resp_valid) begin
                        exp_data  = exp_q.pop_front();
                        issue_cyc = issue_q.pop_front();
                        check_value("resp_data", resp_data, exp_data);
                        // drive cycle to response cycle spans the three stages
                        if (cycle - issue_cyc != `UMEM_LATENCY) begin
                                $display("test %0d: response came %0d cycles after its request, not %0d",
                                         cur_test, cycle - issue_cyc, `UMEM_LATENCY);
                                errors++;
                        end
                end
        end

        //////////////////////////////////////////////////
        // main sequence
        //////////////////////////////////////////////////
        initial begin
                int idx;
                int errs_before;

                rst_n     = 1'b0;
                req_valid = 1'b0;
                req       = '0;
                cur_test  = '0;                                 // test 0 is reset
                idx       = 0;
                load_stimulus();

                errs_before = errors;
                repeat (RESET_CYCLES) @(posedge clk);
                #DRIVE_DLY;
                check_value("resp_data", resp_data, 32'd0);     // cleared by reset
                rst_n = 1'b1;
                repeat (4) @(posedge clk);                      // idle after release
                report_result(errs_before);

                while (idx < vecs.size()) begin
                        cur_test    = vecs[idx].test;
                        errs_before = errors;
                        while (idx < vecs.size() && vecs[idx].test == cur_test) begin
                                issue_request(vecs[idx]);
                                idx++;
                        end
                        @(posedge clk);
                        #DRIVE_DLY;
                        req_valid = 1'b0;                       // end of the burst
                        req       = '0;
                        wait_drain();
                        repeat (`UMEM_LATENCY + 1) @(posedge clk);     // a stray strobe shows here
                        report_result(errs_before);
                end

                $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                         tests_run, tests_failed, checks, errors);
                if (errors == 0) begin
                        $display("Simulation completed successfully");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the unified memory testbench with Verilator, run it, then grade the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -j 0 \
        --top-module unified_mem_tb \
        -f unified_mem.f \
        > build.log 2>&1 \
        || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/Vunified_mem_tb > sim.log 2>&1
cat sim.log

grep -qx "Simulation completed successfully" sim.log \
        && echo "run passed" \
        || { echo "run failed"; exit 1; }

// File: unified_mem.f
+incdir+verilog
verilog/unified_mem_pkg.sv
verilog/mem_req_align.sv
verilog/mem_lane_banks.sv
verilog/mem_load_format.sv
verilog/unified_mem.sv
bench/unified_mem_tb.sv

// File: verilog/mem_lane_banks.sv
`include "unified_mem_consts.svh"

module mem_lane_banks (
        input  logic                            clk,
        input  logic                            rst_n,
        input  unified_mem_pkg::lane_req_t      stage1,
        output unified_mem_pkg::lane_rsp_t      stage2
);

        localparam int DEPTH = 1 << `UMEM_WORD_AW;                      // words per bank

        logic                                   valid_q;
        unified_mem_pkg::mem_op_t               op_q;
        logic [2:0]                             func3_q;
        logic [`UMEM_ADDR_W-`UMEM_WORD_AW-1:0]  offset_q;
        logic [`UMEM_XLEN-1:0]                  word;                   // gathered lane outputs

        //////////////////////////////////////////////////
        // one byte wide bank per lane
        //////////////////////////////////////////////////
        for (genvar i = 0; i < `UMEM_LANES; i++) begin : g_lane
                logic [7:0] mem [DEPTH];                                // contents not reset
                logic [7:0] rd_q;                                       // registered read byte

                always_ff @(posedge clk) begin
                        if (stage1.valid) begin
                                if (stage1.lane_we[i]) begin
                                        mem[stage1.word_addr] <= stage1.lane_wdata[8*i +: 8];
                                end
                                rd_q <= mem[stage1.word_addr];          // old data on a store
                        end
                end

                assign word[8*i +: 8] = rd_q;                           // lane i is byte i
        end

        //////////////////////////////////////////////////
        // control forwarded alongside the read
        //////////////////////////////////////////////////
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        valid_q  <= 1'b0;
                        op_q     <= unified_mem_pkg::OP_FETCH;
                        func3_q  <= '0;
                        offset_q <= '0;
                end else begin
                        valid_q <= stage1.valid;
                        if (stage1.valid) begin                         // hold between items
                                op_q     <= stage1.op;
                                func3_q  <= stage1.func3;
                                offset_q <= stage1.offset;
                        end
                end
        end

        // word lines up with the control regs, same edge
        assign stage2 = '{valid: valid_q, op: op_q, func3: func3_q, offset: offset_q,
                          word: word};

endmodule

// File: verilog/mem_load_format.sv
`include "unified_mem_consts.svh"

module mem_load_format (
        input  logic                            clk,
        input  logic                            rst_n,
        input  unified_mem_pkg::lane_rsp_t      stage2,
        output logic                            resp_valid,
        output logic [`UMEM_XLEN-1:0]           resp_data
);

        logic [`UMEM_ADDR_W-`UMEM_WORD_AW-1:0]  shift_off;      // effective byte offset
        logic [`UMEM_XLEN-1:0]                  shifted;        // addressed data at bit 0
        logic [`UMEM_XLEN-1:0]                  load_data;      // after extension
        logic [`UMEM_XLEN-1:0]                  resp_next;
        logic                                   is_read;        // fetch or load

        //////////////////////////////////////////////////
        // byte select
        //////////////////////////////////////////////////
        always_comb begin
                case (stage2.func3[1:0])
                        2'b10:   shift_off = '0;                                // word
                        2'b01:   shift_off = {stage2.offset[1], 1'b0};          // half, bit 1 only
                        default: shift_off = stage2.offset;                     // byte
                endcase
        end

        assign shifted = stage2.word >> {shift_off, 3'b000};

        //////////////////////////////////////////////////
        // sign / zero extension
        //////////////////////////////////////////////////
        always_comb begin
                case (stage2.func3)
                        `UMEM_F3_B:  load_data = {{24{shifted[7]}}, shifted[7:0]};
                        `UMEM_F3_H:  load_data = {{16{shifted[15]}}, shifted[15:0]};
                        `UMEM_F3_W:  load_data = shifted;
                        `UMEM_F3_BU: load_data = {24'd0, shifted[7:0]};
                        `UMEM_F3_HU: load_data = {16'd0, shifted[15:0]};
                        default:     load_data = '0;                    // unused codes read zero
                endcase
        end

        // a fetch bypasses the formatter entirely
        assign resp_next = (stage2.op == unified_mem_pkg::OP_FETCH) ? stage2.word : load_data;
        assign is_read   = stage2.valid && (stage2.op != unified_mem_pkg::OP_STORE);

        //////////////////////////////////////////////////
        // response register
        //////////////////////////////////////////////////
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        resp_valid <= 1'b0;
                        resp_data  <= '0;
                end else begin
                        resp_valid <= is_read;                  // stores stay silent
                        if (is_read) begin
                                resp_data <= resp_next;         // holds until next read
                        end
                end
        end

endmodule

// File: verilog/mem_req_align.sv
`include "unified_mem_consts.svh"

module mem_req_align (
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            req_valid,
        input  unified_mem_pkg::mem_req_t       req,
        output unified_mem_pkg::lane_req_t      stage1
);

        logic [`UMEM_ADDR_W-1:0]                byte_addr;      // aliased low address bits
        logic [`UMEM_ADDR_W-`UMEM_WORD_AW-1:0]  offset;         // byte within word
        logic                                   is_store;
        logic [`UMEM_LANES-1:0]                 lane_we;
        logic [`UMEM_XLEN-1:0]                  lane_wdata;

        // registered copy of the stage
        logic                                   valid_q;
        unified_mem_pkg::mem_op_t               op_q;
        logic [2:0]                             func3_q;
        logic [`UMEM_ADDR_W-`UMEM_WORD_AW-1:0]  offset_q;
        logic [`UMEM_WORD_AW-1:0]               word_addr_q;
        logic [`UMEM_LANES-1:0]                 lane_we_q;
        logic [`UMEM_XLEN-1:0]                  lane_wdata_q;

        //////////////////////////////////////////////////
        // address split and lane steering
        //////////////////////////////////////////////////
        assign byte_addr = req.addr[`UMEM_ADDR_W-1:0];                  // bits above 9 alias
        assign offset    = byte_addr[`UMEM_ADDR_W-`UMEM_WORD_AW-1:0];
        assign is_store  = (req.op == unified_mem_pkg::OP_STORE);

        always_comb begin
                lane_we    = '0;                                        // fetch and load
                lane_wdata = '0;
                if (is_store) begin
                        case (req.func3)
                                `UMEM_F3_H: begin
                                        // bit 0 dropped, bit 1 picks the half
                                        lane_we    = 4'b0011 << {offset[1], 1'b0};
                                        lane_wdata = `UMEM_XLEN'(req.wdata[15:0]) << {offset[1], 4'b0000};
                                end
                                `UMEM_F3_W: begin
                                        lane_we    = '1;                // all lanes, offset ignored
                                        lane_wdata = req.wdata;
                                end
                                default: begin                          // sb, and any odd code
                                        lane_we    = 4'b0001 << offset;
                                        lane_wdata = `UMEM_XLEN'(req.wdata[7:0]) << {offset, 3'b000};
                                end
                        endcase
                end
        end

        //////////////////////////////////////////////////
        // stage register
        //////////////////////////////////////////////////
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        valid_q   <= 1'b0;
                        op_q      <= unified_mem_pkg::OP_FETCH;
                        lane_we_q <= '0;                                // no stray write after reset
                end else begin
                        valid_q <= req_valid;                           // one cycle strobe
                        if (req_valid) begin
                                op_q      <= req.op;
                                lane_we_q <= lane_we;
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (req_valid) begin                                    // payload only
                        func3_q      <= req.func3;
                        offset_q     <= offset;
                        word_addr_q  <= byte_addr[`UMEM_ADDR_W-1 -: `UMEM_WORD_AW];
                        lane_wdata_q <= lane_wdata;
                end
        end

        assign stage1 = '{valid: valid_q, op: op_q, func3: func3_q, offset: offset_q,
                          word_addr: word_addr_q, lane_we: lane_we_q, lane_wdata: lane_wdata_q};

endmodule

// File: verilog/unified_mem.sv
`include "unified_mem_consts.svh"

module unified_mem (
        input  logic                            clk,
        input  logic                            rst_n,
        input  logic                            req_valid,      // one request per strobe
        input  unified_mem_pkg::mem_req_t       req,
        output logic                            resp_valid,     // fetch/load result strobe
        output logic [`UMEM_XLEN-1:0]           resp_data
);

        //////////////////////////////////////////////////
        // inter stage buses
        //////////////////////////////////////////////////
        unified_mem_pkg::lane_req_t     stage1;         // align -> banks
        unified_mem_pkg::lane_rsp_t     stage2;         // banks -> format

        //////////////////////////////////////////////////
        // stage 1, request alignment
        //////////////////////////////////////////////////
        mem_req_align u_req_align (
                .clk            (clk),
                .rst_n          (rst_n),
                .req_valid      (req_valid),
                .req            (req),
                .stage1         (stage1)
        );

        //////////////////////////////////////////////////
        // stage 2, byte lane banks
        //////////////////////////////////////////////////
        // stores land here, so a later load always sees them
        mem_lane_banks u_lane_banks (
                .clk            (clk),
                .rst_n          (rst_n),
                .stage1         (stage1),
                .stage2         (stage2)
        );

        //////////////////////////////////////////////////
        // stage 3, load formatting
        //////////////////////////////////////////////////
        mem_load_format u_load_format (
                .clk            (clk),
                .rst_n          (rst_n),
                .stage2         (stage2),
                .resp_valid     (resp_valid),
                .resp_data      (resp_data)
        );

endmodule

// File: verilog/unified_mem_consts.svh
`ifndef UNIFIED_MEM_CONSTS_SVH
`define UNIFIED_MEM_CONSTS_SVH

//////////////////////////////////////////////////
// memory geometry
//////////////////////////////////////////////////
`define UMEM_XLEN       32      // data and address bus width
`define UMEM_ADDR_W     10      // byte address bits in use, 1 KiB
`define UMEM_LANES      4       // bytes per word
`define UMEM_WORD_AW    8       // word address bits, 256 words per bank

//////////////////////////////////////////////////
// func3 access size codes
//////////////////////////////////////////////////
`define UMEM_F3_B       3'd0    // byte, sign extended
`define UMEM_F3_H       3'd1    // halfword, sign extended
`define UMEM_F3_W       3'd2    // full word
`define UMEM_F3_BU      3'd4    // byte, zero extended
`define UMEM_F3_HU      3'd5    // halfword, zero extended

// request sampling edge to response register edge
`define UMEM_LATENCY    3       // one cycle per stage

`endif

// File: verilog/unified_mem_pkg.sv
`include "unified_mem_consts.svh"

package unified_mem_pkg;

        //////////////////////////////////////////////////
        // operation encoding
        //////////////////////////////////////////////////
        typedef enum logic [1:0] {
                OP_FETCH = 2'd0,        // instruction fetch, whole word
                OP_LOAD  = 2'd1,        // data load, sized by func3
                OP_STORE = 2'd2         // data store, sized by func3
        } mem_op_t;

        //////////////////////////////////////////////////
        // external request, 69 bits
        //////////////////////////////////////////////////
        typedef struct packed {
                mem_op_t                op;     // what to do
                logic [2:0]             func3;  // size and sign
                logic [`UMEM_XLEN-1:0]  addr;   // byte address, upper bits ignored
                logic [`UMEM_XLEN-1:0]  wdata;  // store data, right aligned
        } mem_req_t;

        //////////////////////////////////////////////////
        // align stage -> lane banks, 52 bits
        //////////////////////////////////////////////////
        typedef struct packed {
                logic                                   valid;          // item strobe
                mem_op_t                                op;
                logic [2:0]                             func3;
                logic [`UMEM_ADDR_W-`UMEM_WORD_AW-1:0]  offset;         // byte in word
                logic [`UMEM_WORD_AW-1:0]               word_addr;
                logic [`UMEM_LANES-1:0]                 lane_we;        // zero unless store
                logic [`UMEM_XLEN-1:0]                  lane_wdata;     // data already in lanes
        } lane_req_t;

        //////////////////////////////////////////////////
        // lane banks -> load format, 40 bits
        //////////////////////////////////////////////////
        typedef struct packed {
                logic                                   valid;          // item strobe
                mem_op_t                                op;
                logic [2:0]                             func3;
                logic [`UMEM_ADDR_W-`UMEM_WORD_AW-1:0]  offset;
                logic [`UMEM_XLEN-1:0]                  word;           // raw word, little endian
        } lane_rsp_t;

endpackage
